//--- Bender.yml
package:
  name: fp16_divsqrt

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/fp_format_pkg.sv
      - rtl/divsqrt_ctrl_pkg.sv
      - rtl/operand_unpack.sv
      - rtl/mant_divider.sv
      - rtl/mant_sqrt.sv
      - rtl/result_assembler.sv
      - rtl/divsqrt_ctrl.sv
      - rtl/divsqrt_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_divsqrt.sv

//--- include/divsqrt_config.svh
/*
  Fixed FP16 configuration of the divide and square-root unit.
  Changing the widths alone does not retarget the unit to another format.
*/
`ifndef DIVSQRT_CONFIG_SVH
`define DIVSQRT_CONFIG_SVH

// FP16 field layout
`define DIVSQRT_EXP_W 5
`define DIVSQRT_MAN_W 10
`define DIVSQRT_BIAS  15

// Engine iterations, one result bit per cycle
`define DIVSQRT_ITERS 12

// Width of the tag carried with each operation
`define DIVSQRT_TAG_W 4

// Canonical quiet NaN returned for invalid operations
`define DIVSQRT_QNAN  16'h7E00

`endif

//--- rtl/divsqrt_ctrl.sv
/*
  Handshake control of the unit: one operation in flight at a time.
  In HOLD a new request is taken in the same cycle the result leaves.
*/
`timescale 1ns/1ps

module divsqrt_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          in_valid_i,
  input  divsqrt_ctrl_pkg::divsqrt_op_e op_i,
  input  divsqrt_ctrl_pkg::tag_t        tag_i,
  output logic                          in_ready_o,
  output logic                          accept_o,
  output logic                          div_start_o,
  output logic                          sqrt_start_o,
  input  logic                          rsp_done_i,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output divsqrt_ctrl_pkg::tag_t        tag_o,
  output logic                          busy_o
);
  import divsqrt_ctrl_pkg::*;

  ctrl_state_e state_q, state_d;
  tag_t        tag_q;

  // --------------------
  // Handshakes
  // --------------------
  assign in_ready_o   = (state_q == IDLE) || ((state_q == HOLD) && out_ready_i);
  assign accept_o     = in_valid_i && in_ready_o;
  // Start strobe to the engine of the requested operation
  assign div_start_o  = accept_o && (op_i == OP_DIV);
  assign sqrt_start_o = accept_o && (op_i == OP_SQRT);
  assign out_valid_o  = (state_q == HOLD);
  assign busy_o       = (state_q != IDLE);

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (accept_o) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        // Result registered at the same edge
        if (rsp_done_i) begin
          state_d = HOLD;
        end
      end
      HOLD: begin
        if (out_ready_i) begin
          state_d = accept_o ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Tag follows its operation
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      tag_q <= tag_i;
    end
  end

  assign tag_o = tag_q;

endmodule

//--- rtl/divsqrt_ctrl_pkg.sv
/*
  Operation, control and transfer types of the divide/sqrt unit.
  Only round toward zero exists, so no rounding mode is carried.
*/
`include "divsqrt_config.svh"

package divsqrt_ctrl_pkg;

  // Operation select
  typedef enum logic {
    OP_DIV,
    OP_SQRT
  } divsqrt_op_e;

  // Control FSM
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    HOLD
  } ctrl_state_e;

  // IEEE status flags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef logic [`DIVSQRT_TAG_W-1:0] tag_t;

  // Request from upstream
  typedef struct packed {
    divsqrt_op_e          op;
    fp_format_pkg::fp16_t a;
    fp_format_pkg::fp16_t b;
    tag_t                 tag;
  } divsqrt_req_t;

  // Response to downstream
  typedef struct packed {
    fp_format_pkg::fp16_t result;
    status_t              status;
    tag_t                 tag;
  } divsqrt_rsp_t;

  // Captured at acceptance for the result assembler
  typedef struct packed {
    logic                 use_special;
    fp_format_pkg::fp16_t result;
    status_t              status;
    logic                 sign;
    fp_format_pkg::exp_t  exp;
  } special_t;

endpackage

//--- rtl/divsqrt_top.sv
/*
  FP16 divide and square-root unit, round toward zero only.
  Fixed latency of 13 cycles from acceptance to out_valid_o.
  rsp_o is held stable until out_ready_i takes it.
*/
`timescale 1ns/1ps
`include "divsqrt_config.svh"

module divsqrt_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  divsqrt_ctrl_pkg::divsqrt_req_t req_i,
  input  logic                           in_valid_i,
  output logic                           in_ready_o,
  output divsqrt_ctrl_pkg::divsqrt_rsp_t rsp_o,
  output logic                           out_valid_o,
  input  logic                           out_ready_i,
  output logic                           busy_o
);
  import fp_format_pkg::*;
  import divsqrt_ctrl_pkg::*;

  logic                      accept, div_start, sqrt_start, rsp_done;
  unpacked_t                 a_unp, b_unp;
  special_t                  special;
  logic                      div_done, div_sticky;
  logic                      sqrt_done, sqrt_sticky;
  logic [`DIVSQRT_ITERS-1:0] quot, root;

  // Control and handshakes
  divsqrt_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .op_i         (req_i.op),
    .tag_i        (req_i.tag),
    .in_ready_o   (in_ready_o),
    .accept_o     (accept),
    .div_start_o  (div_start),
    .sqrt_start_o (sqrt_start),
    .rsp_done_i   (rsp_done),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .tag_o        (rsp_o.tag),
    .busy_o       (busy_o)
  );

  operand_unpack u_unpack (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .accept_i  (accept),
    .op_i      (req_i.op),
    .a_i       (req_i.a),
    .b_i       (req_i.b),
    .a_unp_o   (a_unp),
    .b_unp_o   (b_unp),
    .special_o (special)
  );

  // --------------------
  // Engines, side by side
  // --------------------
  mant_divider u_div (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (div_start),
    .num_i    (a_unp.sig),
    .den_i    (b_unp.sig),
    .done_o   (div_done),
    .quot_o   (quot),
    .sticky_o (div_sticky)
  );

  mant_sqrt u_sqrt (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .start_i   (sqrt_start),
    .rad_i     (a_unp.sig),
    .odd_exp_i (a_unp.exp[0]),
    .done_o    (sqrt_done),
    .root_o    (root),
    .sticky_o  (sqrt_sticky)
  );

  result_assembler u_asm (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .div_done_i    (div_done),
    .sqrt_done_i   (sqrt_done),
    .quot_i        (quot),
    .div_sticky_i  (div_sticky),
    .root_i        (root),
    .sqrt_sticky_i (sqrt_sticky),
    .special_i     (special),
    .rsp_done_o    (rsp_done),
    .result_o      (rsp_o.result),
    .status_o      (rsp_o.status)
  );

endmodule

//--- rtl/fp_format_pkg.sv
/*
  Number-format types for FP16.
  Subnormals are not represented: a zero exponent field classifies as zero.
*/
`include "divsqrt_config.svh"

package fp_format_pkg;

  // One FP16 word: sign, exponent, fraction
  typedef logic [`DIVSQRT_EXP_W+`DIVSQRT_MAN_W:0] fp16_t;

  // Significand with hidden bit
  typedef logic [`DIVSQRT_MAN_W:0] sig_t;

  // Unbiased exponent, signed, holds quotient range plus normalisation
  typedef logic signed [7:0] exp_t;

  // Operand classification
  typedef struct packed {
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_snan;
    logic sign;
  } fp_class_t;

  // Operand split into its parts
  typedef struct packed {
    fp_class_t cls;
    exp_t      exp;
    sig_t      sig;
  } unpacked_t;

endpackage

//--- rtl/mant_divider.sv
/*
  Restoring radix-2 divider of two normal significands.
  Both inputs need the hidden bit set; the result weights run 2^0 down to 2^-11.
  A start while busy restarts the division.
*/
`timescale 1ns/1ps
`include "divsqrt_config.svh"

module mant_divider (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      start_i,
  input  fp_format_pkg::sig_t       num_i,
  input  fp_format_pkg::sig_t       den_i,
  output logic                      done_o,
  output logic [`DIVSQRT_ITERS-1:0] quot_o,
  output logic                      sticky_o
);
  import fp_format_pkg::*;

  localparam int ITERS = `DIVSQRT_ITERS;
  localparam int CNT_W = $clog2(ITERS + 1);
  // One spare bit for the doubled partial remainder
  localparam int REM_W = $bits(sig_t) + 1;

  logic [REM_W-1:0] rem_q, rem_diff, rem_keep;
  sig_t             den_q;
  logic [ITERS-1:0] quot_q;
  logic [CNT_W-1:0] cnt_q;
  logic             done_q;
  logic             bit_ok;

  // Trial subtraction
  assign bit_ok   = (rem_q >= {1'b0, den_q});
  assign rem_diff = rem_q - {1'b0, den_q};
  assign rem_keep = bit_ok ? rem_diff : rem_q;

  // --------------------
  // Datapath
  // --------------------
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rem_q  <= {1'b0, num_i};
      den_q  <= den_i;
      quot_q <= '0;
    end else if (cnt_q != '0) begin
      // Remainder stays below den, so the shift never overflows
      rem_q  <= rem_keep << 1;
      quot_q <= {quot_q[ITERS-2:0], bit_ok};
    end
  end

  // Iteration count and done strobe
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= (cnt_q == CNT_W'(1));
      if (start_i) begin
        cnt_q <= CNT_W'(ITERS);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  assign done_o   = done_q;
  assign quot_o   = quot_q;
  // Non-zero remainder left after the last step
  assign sticky_o = |rem_q;

endmodule

//--- rtl/mant_sqrt.sv
/*
  Radix-2 digit-recurrence square root of a normal significand.
  odd_exp_i doubles the radicand so the exponent can be halved exactly.
  The root weights run 2^0 down to 2^-11; the top root bit is always set.
*/
`timescale 1ns/1ps
`include "divsqrt_config.svh"

module mant_sqrt (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      start_i,
  input  fp_format_pkg::sig_t       rad_i,
  input  logic                      odd_exp_i,
  output logic                      done_o,
  output logic [`DIVSQRT_ITERS-1:0] root_o,
  output logic                      sticky_o
);
  localparam int ITERS = `DIVSQRT_ITERS;
  localparam int CNT_W = $clog2(ITERS + 1);
  // Two radicand bits consumed per step
  localparam int RAD_W = 2 * ITERS;
  localparam int REM_W = ITERS + 2;

  logic [RAD_W-1:0] rad_ext;
  logic [RAD_W-1:0] rad_q;
  logic [REM_W-1:0] rem_q, rem_next;
  logic [REM_W+1:0] rem_try, trial;
  logic [ITERS-1:0] root_q;
  logic [CNT_W-1:0] cnt_q;
  logic             done_q;
  logic             bit_ok;

  // Radicand scaled to an integer, top bit free for the odd-exponent doubling
  assign rad_ext = {1'b0, rad_i, {ITERS{1'b0}}};

  // --------------------
  // Recurrence step
  // --------------------
  always_comb begin
    // Bring down the next bit pair
    rem_try  = {rem_q, rad_q[RAD_W-1 -: 2]};
    // Trial value 4*root + 1
    trial    = {2'b00, root_q, 2'b01};
    bit_ok   = (rem_try >= trial);
    rem_next = bit_ok ? REM_W'(rem_try - trial) : REM_W'(rem_try);
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rad_q  <= odd_exp_i ? (rad_ext << 1) : rad_ext;
      rem_q  <= '0;
      root_q <= '0;
    end else if (cnt_q != '0) begin
      rad_q  <= rad_q << 2;
      rem_q  <= rem_next;
      root_q <= {root_q[ITERS-2:0], bit_ok};
    end
  end

  // Iteration count and done strobe
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= (cnt_q == CNT_W'(1));
      if (start_i) begin
        cnt_q <= CNT_W'(ITERS);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  assign done_o   = done_q;
  assign root_o   = root_q;
  assign sticky_o = |rem_q;

endmodule

//--- rtl/operand_unpack.sv
/*
  Classifies both FP16 operands and resolves the special cases.
  Subnormal operands count as zero. For sqrt the b operand is ignored.
  The special-case record is captured on the accepting edge only.
*/
`timescale 1ns/1ps
`include "divsqrt_config.svh"

module operand_unpack (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          accept_i,
  input  divsqrt_ctrl_pkg::divsqrt_op_e op_i,
  input  fp_format_pkg::fp16_t          a_i,
  input  fp_format_pkg::fp16_t          b_i,
  output fp_format_pkg::unpacked_t      a_unp_o,
  output fp_format_pkg::unpacked_t      b_unp_o,
  output divsqrt_ctrl_pkg::special_t    special_o
);
  import fp_format_pkg::*;
  import divsqrt_ctrl_pkg::*;

  localparam int EXP_W = `DIVSQRT_EXP_W;
  localparam int MAN_W = `DIVSQRT_MAN_W;

  unpacked_t a_unp, b_unp;
  special_t  special_d, special_q;
  logic      res_sign;
  fp16_t     inf_res, zero_res;

  // Split one word and classify it
  function automatic unpacked_t classify(input fp16_t w);
    logic [EXP_W-1:0] e;
    logic [MAN_W-1:0] f;
    unpacked_t        u;
    e = w[MAN_W +: EXP_W];
    f = w[MAN_W-1:0];
    u.cls.sign    = w[EXP_W+MAN_W];
    u.cls.is_zero = (e == '0);
    u.cls.is_inf  = (&e) && (f == '0);
    u.cls.is_nan  = (&e) && (f != '0);
    // Quiet bit clear means signalling
    u.cls.is_snan = u.cls.is_nan && !f[MAN_W-1];
    u.exp = exp_t'(e) - exp_t'(`DIVSQRT_BIAS);
    // Hidden bit only for normal numbers
    u.sig = {!u.cls.is_zero, f};
    return u;
  endfunction

  assign a_unp   = classify(a_i);
  assign b_unp   = classify(b_i);
  assign a_unp_o = a_unp;
  assign b_unp_o = b_unp;

  // --------------------
  // Special cases
  // --------------------
  assign res_sign = (op_i == OP_DIV) ? (a_unp.cls.sign ^ b_unp.cls.sign) : 1'b0;
  assign inf_res  = {res_sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
  assign zero_res = {res_sign, {(EXP_W+MAN_W){1'b0}}};

  always_comb begin
    special_d             = '0;
    special_d.sign        = res_sign;
    special_d.use_special = 1'b1;
    if (op_i == OP_DIV) begin
      // Exponent of a/b before normalisation
      special_d.exp = a_unp.exp - b_unp.exp;
      if (a_unp.cls.is_nan || b_unp.cls.is_nan) begin
        special_d.result    = `DIVSQRT_QNAN;
        special_d.status.nv = a_unp.cls.is_snan | b_unp.cls.is_snan;
      end else if ((a_unp.cls.is_zero && b_unp.cls.is_zero) ||
                   (a_unp.cls.is_inf && b_unp.cls.is_inf)) begin
        // 0/0 and inf/inf
        special_d.result    = `DIVSQRT_QNAN;
        special_d.status.nv = 1'b1;
      end else if (a_unp.cls.is_inf) begin
        special_d.result = inf_res;
      end else if (b_unp.cls.is_zero) begin
        // Finite non-zero over zero
        special_d.result    = inf_res;
        special_d.status.dz = 1'b1;
      end else if (a_unp.cls.is_zero || b_unp.cls.is_inf) begin
        special_d.result = zero_res;
      end else begin
        special_d.use_special = 1'b0;
      end
    end else begin
      // Floor of half the exponent, arithmetic shift
      special_d.exp = a_unp.exp >>> 1;
      if (a_unp.cls.is_nan) begin
        special_d.result    = `DIVSQRT_QNAN;
        special_d.status.nv = a_unp.cls.is_snan;
      end else if (a_unp.cls.is_zero) begin
        // sqrt(-0) keeps its sign
        special_d.result = {a_unp.cls.sign, {(EXP_W+MAN_W){1'b0}}};
      end else if (a_unp.cls.sign) begin
        special_d.result    = `DIVSQRT_QNAN;
        special_d.status.nv = 1'b1;
      end else if (a_unp.cls.is_inf) begin
        special_d.result = inf_res;
      end else begin
        special_d.use_special = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      special_q <= '0;
    end else if (accept_i) begin
      special_q <= special_d;
    end
  end

  assign special_o = special_q;

endmodule

//--- rtl/result_assembler.sv
/*
  Normalises the engine result, truncates toward zero and applies range rules.
  Results below the normal range flush to signed zero.
  Output registers only change on an engine done strobe.
*/
`timescale 1ns/1ps
`include "divsqrt_config.svh"

module result_assembler (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       div_done_i,
  input  logic                       sqrt_done_i,
  input  logic [`DIVSQRT_ITERS-1:0]  quot_i,
  input  logic                       div_sticky_i,
  input  logic [`DIVSQRT_ITERS-1:0]  root_i,
  input  logic                       sqrt_sticky_i,
  input  divsqrt_ctrl_pkg::special_t special_i,
  output logic                       rsp_done_o,
  output fp_format_pkg::fp16_t       result_o,
  output divsqrt_ctrl_pkg::status_t  status_o
);
  import fp_format_pkg::*;
  import divsqrt_ctrl_pkg::*;

  localparam int   ITERS   = `DIVSQRT_ITERS;
  localparam int   EXP_W   = `DIVSQRT_EXP_W;
  localparam int   MAN_W   = `DIVSQRT_MAN_W;
  localparam exp_t EXP_INF = exp_t'((1 << EXP_W) - 1);

  logic [ITERS-1:0] res_bits;
  logic [MAN_W-1:0] frac;
  logic             sticky, dropped;
  exp_t             exp_norm, exp_biased;
  fp16_t            result_d, result_q;
  status_t          status_d, status_q;

  // Only the engine of the accepted operation finishes
  assign res_bits = div_done_i ? quot_i : root_i;
  assign sticky   = div_done_i ? div_sticky_i : sqrt_sticky_i;

  // --------------------
  // Normalise
  // --------------------
  always_comb begin
    if (res_bits[ITERS-1]) begin
      frac     = res_bits[ITERS-2 -: MAN_W];
      dropped  = res_bits[0];
      exp_norm = special_i.exp;
    end else begin
      // Quotient below one, shift left by one
      frac     = res_bits[ITERS-3 -: MAN_W];
      dropped  = 1'b0;
      exp_norm = special_i.exp - exp_t'(1);
    end
    exp_biased = exp_norm + exp_t'(`DIVSQRT_BIAS);
  end

  // Range rules, special results take priority
  always_comb begin
    status_d = '0;
    if (special_i.use_special) begin
      result_d = special_i.result;
      status_d = special_i.status;
    end else if (exp_biased >= EXP_INF) begin
      // RTZ overflow saturates to the largest finite value
      result_d    = {special_i.sign, {(EXP_W-1){1'b1}}, 1'b0, {MAN_W{1'b1}}};
      status_d.of = 1'b1;
      status_d.nx = 1'b1;
    end else if (exp_biased <= exp_t'(0)) begin
      result_d    = {special_i.sign, {(EXP_W+MAN_W){1'b0}}};
      status_d.uf = 1'b1;
      status_d.nx = 1'b1;
    end else begin
      result_d    = {special_i.sign, exp_biased[EXP_W-1:0], frac};
      status_d.nx = dropped | sticky;
    end
  end

  assign rsp_done_o = div_done_i | sqrt_done_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
      status_q <= '0;
    end else if (rsp_done_o) begin
      result_q <= result_d;
      status_q <= status_d;
    end
  end

  assign result_o = result_q;
  assign status_o = status_q;

endmodule

//--- sources.f
+incdir+include
rtl/fp_format_pkg.sv
rtl/divsqrt_ctrl_pkg.sv
rtl/operand_unpack.sv
rtl/mant_divider.sv
rtl/mant_sqrt.sv
rtl/result_assembler.sv
rtl/divsqrt_ctrl.sv
rtl/divsqrt_top.sv
tb/tb_divsqrt.sv

//--- tb/tb_divsqrt.sv
/*
  Testbench of the FP16 divide/sqrt unit, with an integer model and a scoreboard.
  All requests are built at time zero from a fixed seed; back-pressure is random.
  The model assumes round toward zero and subnormals treated as zero.
*/
`timescale 1ns/1ps
`include "divsqrt_config.svh"

module tb_divsqrt;
  import fp_format_pkg::*;
  import divsqrt_ctrl_pkg::*;

  localparam int WAIT_LIMIT = 500;
  localparam int LATENCY    = `DIVSQRT_ITERS + 1;
  localparam int NUM_TESTS  = 4;

  logic         clk_i;
  logic         rst_n_i;
  divsqrt_req_t req_i;
  logic         in_valid_i;
  logic         in_ready_o;
  divsqrt_rsp_t rsp_o;
  logic         out_valid_o;
  logic         out_ready_i;
  logic         busy_o;

  integer       seed = 32'h7a646003;
  int           errors = 0;
  int           checked = 0;
  int           cycle = 0;
  int           stall_w = 0;
  int           accept_edge = 0;
  logic         in_flight = 1'b0;
  logic         was_valid = 1'b0;
  logic         was_stalled = 1'b0;
  divsqrt_rsp_t last_rsp;
  tag_t         next_tag = '0;

  // Scoreboard and prebuilt stimulus
  divsqrt_rsp_t expected_q[$];
  divsqrt_req_t req_list[$];
  int           gap_list[$];
  string        test_name[NUM_TESTS];
  int           test_first[NUM_TESTS];
  int           test_count[NUM_TESTS];
  int           test_stall[NUM_TESTS];

  divsqrt_top divsqrt_top_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .rsp_o       (rsp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Edge counter for the latency check
  always @(posedge clk_i) cycle <= cycle + 1;

  task automatic log_error(input string msg);
    errors++;
    $display("Fail at %0t ns: %s", $time, msg);
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s at %0t ns", why, $time);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  // --------------------
  // Reference model
  // --------------------
  function automatic int int_sqrt(input int v);
    int r;
    int t;
    int b;
    r = 0;
    // Greedy bit search for the largest root with root*root <= v
    for (b = 11; b >= 0; b--) begin
      t = r | (1 << b);
      if (t * t <= v) r = t;
    end
    return r;
  endfunction

  // Range rules on an 11-bit significand m with unbiased exponent e
  function automatic divsqrt_rsp_t pack_normal(input logic sg, input int e, input int m,
                                               input logic inexact);
    divsqrt_rsp_t rs;
    int           be;
    rs = '0;
    be = e + `DIVSQRT_BIAS;
    if (be >= 31) begin
      rs.result    = {sg, 15'h7BFF};
      rs.status.of = 1'b1;
      rs.status.nx = 1'b1;
    end else if (be <= 0) begin
      rs.result    = {sg, 15'h0000};
      rs.status.uf = 1'b1;
      rs.status.nx = 1'b1;
    end else begin
      rs.result    = {sg, be[4:0], m[9:0]};
      rs.status.nx = inexact;
    end
    return rs;
  endfunction

  function automatic divsqrt_rsp_t model_op(input divsqrt_req_t rq);
    divsqrt_rsp_t rs;
    logic [4:0]   xa, xb;
    logic [9:0]   fa, fb;
    logic         sign_a, sign_b, sg;
    logic         za, zb, ia, ib, na, nb;
    int           ma, mb, e, num, odd, rad, root;
    rs     = '0;
    xa     = rq.a[14:10];
    xb     = rq.b[14:10];
    fa     = rq.a[9:0];
    fb     = rq.b[9:0];
    sign_a = rq.a[15];
    sign_b = rq.b[15];
    // Zero exponent field counts as zero including subnormals
    za = (xa == 5'h00);
    zb = (xb == 5'h00);
    ia = (xa == 5'h1F) && (fa == 10'h000);
    ib = (xb == 5'h1F) && (fb == 10'h000);
    na = (xa == 5'h1F) && (fa != 10'h000);
    nb = (xb == 5'h1F) && (fb != 10'h000);
    ma = 1024 + fa;
    mb = 1024 + fb;
    if (rq.op == OP_DIV) begin
      sg = sign_a ^ sign_b;
      if (na || nb) begin
        rs.result    = `DIVSQRT_QNAN;
        rs.status.nv = (na && !fa[9]) || (nb && !fb[9]);
      end else if ((za && zb) || (ia && ib)) begin
        rs.result    = `DIVSQRT_QNAN;
        rs.status.nv = 1'b1;
      end else if (ia) begin
        rs.result = {sg, 5'h1F, 10'h000};
      end else if (zb) begin
        rs.result    = {sg, 5'h1F, 10'h000};
        rs.status.dz = 1'b1;
      end else if (za || ib) begin
        rs.result = {sg, 15'h0000};
      end else begin
        // Biases cancel in the difference
        e = int'(xa) - int'(xb);
        if (ma >= mb) begin
          num = ma << 10;
        end else begin
          num = ma << 11;
          e   = e - 1;
        end
        rs = pack_normal(sg, e, num / mb, (num % mb) != 0);
      end
    end else begin
      if (na) begin
        rs.result    = `DIVSQRT_QNAN;
        rs.status.nv = !fa[9];
      end else if (za) begin
        rs.result = {sign_a, 15'h0000};
      end else if (sign_a) begin
        rs.result    = `DIVSQRT_QNAN;
        rs.status.nv = 1'b1;
      end else if (ia) begin
        rs.result = 16'h7C00;
      end else begin
        e    = int'(xa) - `DIVSQRT_BIAS;
        odd  = e & 1;
        // Odd exponent moves one factor of two into the radicand
        rad  = ma << (10 + odd);
        root = int_sqrt(rad);
        rs   = pack_normal(1'b0, (e - odd) / 2, root, (root * root) != rad);
      end
    end
    rs.tag = rq.tag;
    return rs;
  endfunction

  // --------------------
  // Stimulus building
  // --------------------
  function automatic fp16_t rand_normal(input logic allow_neg);
    int    r;
    fp16_t w;
    r         = $random(seed);
    w[15]     = allow_neg & r[31];
    w[14:10]  = (r[20:16] % 5'd30) + 5'd1;
    w[9:0]    = r[9:0];
    return w;
  endfunction

  task automatic add_req(input divsqrt_op_e op, input fp16_t a, input fp16_t b, input int gap);
    divsqrt_req_t rq;
    rq.op    = op;
    rq.a     = a;
    rq.b     = b;
    rq.tag   = next_tag;
    next_tag = next_tag + 1'b1;
    req_list.push_back(rq);
    gap_list.push_back(gap);
  endtask

  task automatic open_test(input int idx, input string name, input int stall);
    test_name[idx]  = name;
    test_first[idx] = req_list.size();
    test_stall[idx] = stall;
  endtask

  task automatic build_tests();
    fp16_t       a;
    fp16_t       b;
    divsqrt_op_e op;
    int          r;
    open_test(0, "divide", 4);
    repeat (60) begin
      a = rand_normal(1'b1);
      b = rand_normal(1'b1);
      r = $random(seed);
      add_req(OP_DIV, a, b, r & 3);
    end
    test_count[0] = req_list.size() - test_first[0];
    // Random b that sqrt must ignore
    open_test(1, "sqrt", 4);
    repeat (60) begin
      a = rand_normal(1'b0);
      b = rand_normal(1'b1);
      r = $random(seed);
      add_req(OP_SQRT, a, b, r & 3);
    end
    test_count[1] = req_list.size() - test_first[1];
    open_test(2, "special", 6);
    add_req(OP_DIV,  16'h0000, 16'h0000, 1);
    add_req(OP_DIV,  16'h7C00, 16'hFC00, 1);
    add_req(OP_DIV,  16'h3C00, 16'h0000, 1);
    add_req(OP_DIV,  16'hC000, 16'h8000, 1);
    add_req(OP_DIV,  16'h7C00, 16'h0000, 1);
    add_req(OP_DIV,  16'h7D00, 16'h3C00, 1);
    add_req(OP_DIV,  16'h7E00, 16'h3C00, 1);
    add_req(OP_DIV,  16'h7800, 16'h0400, 1);
    add_req(OP_DIV,  16'h7BFF, 16'h3BFF, 1);
    add_req(OP_DIV,  16'h0400, 16'h7800, 1);
    add_req(OP_DIV,  16'h0400, 16'h3C00, 1);
    add_req(OP_DIV,  16'h0200, 16'h3C00, 1);
    add_req(OP_DIV,  16'h3C00, 16'h7C00, 1);
    add_req(OP_DIV,  16'hFC00, 16'h3C00, 1);
    add_req(OP_SQRT, 16'hC400, 16'h0000, 1);
    add_req(OP_SQRT, 16'h7C01, 16'h0000, 1);
    add_req(OP_SQRT, 16'h8000, 16'h0000, 1);
    add_req(OP_SQRT, 16'h7C00, 16'h0000, 1);
    add_req(OP_SQRT, 16'h0001, 16'h0000, 1);
    add_req(OP_SQRT, 16'h4400, 16'h7D00, 1);
    test_count[2] = req_list.size() - test_first[2];
    // Back to back under heavy back-pressure
    open_test(3, "stream", 10);
    repeat (60) begin
      r  = $random(seed);
      op = r[0] ? OP_SQRT : OP_DIV;
      a  = rand_normal(op == OP_DIV);
      b  = rand_normal(1'b1);
      add_req(op, a, b, 0);
    end
    test_count[3] = req_list.size() - test_first[3];
  endtask

  // --------------------
  // Driver and sink
  // --------------------
  task automatic send_req(input divsqrt_req_t rq, input int gap);
    int n;
    repeat (gap) @(posedge clk_i);
    req_i      <= rq;
    in_valid_i <= 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!in_ready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!in_ready_o) begin
      abort_run("request was not accepted");
    end else begin
      @(posedge clk_i);
      in_valid_i <= 1'b0;
    end
  endtask

  task automatic drain(input string name);
    int n;
    n = 0;
    while ((expected_q.size() != 0 || in_flight) && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      n++;
    end
    if (expected_q.size() != 0 || in_flight) begin
      abort_run({"results of test ", name, " never arrived"});
    end
  endtask

  // Random ready stretches of 1 to 8 cycles
  initial begin : sink
    int   r;
    int   stretch;
    logic ready_lvl;
    out_ready_i = 1'b0;
    stretch     = 0;
    ready_lvl   = 1'b0;
    forever begin
      @(posedge clk_i);
      if (rst_n_i) begin
        if (stretch == 0) begin
          r         = $random(seed);
          ready_lvl = (r[3:0] >= stall_w);
          stretch   = 1 + r[6:4];
        end
        out_ready_i <= ready_lvl;
        stretch--;
      end
    end
  end

  // --------------------
  // Monitor sampling between edges
  // --------------------
  always @(negedge clk_i) begin : monitor
    divsqrt_rsp_t want;
    logic         take;
    logic         acc;
    if (rst_n_i) begin
      take = out_valid_o && out_ready_i;
      acc  = in_valid_i && in_ready_o;
      assert (busy_o == in_flight)
        else log_error($sformatf("busy_o is %b, expected %b", busy_o, in_flight));
      if (!in_flight) begin
        assert (in_ready_o) else log_error("in_ready_o low while idle");
      end
      if (in_flight && !out_valid_o) begin
        assert (!in_ready_o) else log_error("in_ready_o high while an operation runs");
      end
      if (out_valid_o && !out_ready_i) begin
        assert (!in_ready_o) else log_error("in_ready_o high while the result is held");
      end
      // New work must be taken in the cycle the result leaves
      if (out_valid_o && out_ready_i) begin
        assert (in_ready_o) else log_error("in_ready_o low while the result leaves");
      end
      // Held response must not move
      if (was_stalled) begin
        assert (out_valid_o && rsp_o == last_rsp)
          else log_error("held response changed under back-pressure");
      end
      if (out_valid_o && !was_valid) begin
        assert (cycle == accept_edge + LATENCY)
          else log_error($sformatf("out_valid_o rose %0d edges after acceptance, expected %0d",
                                   cycle - accept_edge, LATENCY));
      end
      if (take) begin
        assert (expected_q.size() != 0) else begin
          errors++;
          $display("Response arrived with no request outstanding at %0t ns", $time);
        end
        if (expected_q.size() != 0) begin
          want = expected_q.pop_front();
          checked++;
          assert (rsp_o.tag == want.tag)
            else log_error($sformatf("tag %0d, expected %0d", rsp_o.tag, want.tag));
          assert (rsp_o.result == want.result && rsp_o.status == want.status)
            else log_error($sformatf("tag %0d result %h flags %b, expected %h flags %b",
                                     want.tag, rsp_o.result, rsp_o.status,
                                     want.result, want.status));
        end
      end
      if (acc) begin
        expected_q.push_back(model_op(req_i));
        accept_edge = cycle + 1;
      end
      in_flight   = (in_flight && !take) || acc;
      was_valid   = out_valid_o;
      was_stalled = out_valid_o && !out_ready_i;
      last_rsp    = rsp_o;
    end
  end

  initial begin : stimulus
    int errs_before;
    int failed;
    int t;
    int i;
    in_valid_i = 1'b0;
    req_i      = '0;
    rst_n_i    = 1'b0;
    failed     = 0;
    build_tests();
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!busy_o && !out_valid_o && in_ready_o)
      else log_error("handshake outputs wrong after reset");
    @(posedge clk_i);
    for (t = 0; t < NUM_TESTS; t++) begin
      errs_before = errors;
      stall_w    <= test_stall[t];
      for (i = test_first[t]; i < test_first[t] + test_count[t]; i++) begin
        send_req(req_list[i], gap_list[i]);
      end
      drain(test_name[t]);
      if (errors != errs_before) failed++;
      $display("Test %s: %0d operations, %0d errors", test_name[t], test_count[t],
               errors - errs_before);
    end
    $display("Tests run %0d, tests failed %0d, responses checked %0d, errors %0d",
             NUM_TESTS, failed, checked, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
